// File: run.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line
verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }

// File: sim/clock_gen.sv
// testbench clock with a period of 100
// synchronous reset held for the first three cycles
module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: sim/rv_stim.txt
// columns: hex words, @ gives the word index; program at @000, data for 0x100 at @080
// @0a0 holds the store count, then address data sel per store, then the expected halt
@000
10000093 FF900113 00500193 00310233 402182B3 00314333 // setup, add, sub, xor
003163B3 00317433 003124B3 00313533 003195B3 40315633 // or, and, slt, sltu, sll, sra
00415693 40115713 01C19793 FFA12813 0F01C893           // srli, srai, slli, slti, xori
0440A023 0450A223 0460A423 0470A623 0480A823 0490AA23 04A0AC23
04B0AE23 06C0A023 06D0A223 06E0A423 06F0A623 0700A823 0710AA23
09108023 091080A3 09108123 091081A3 08E09223 08E09323 // sb x4, sh x2
00308903 0020C983 00209A03 0000DA83 0040AB03           // lb lbu lh lhu lw
0720AC23 0730AE23 0940A423 0950A623 0960A823
00318463 0E20AE23 00310463 0830AA23 // beq taken, not taken
00311463 0E20AE23 00319463 0830AC23 // bne
00314463 0E20AE23 0021C463 0830AE23 // blt
0021D463 0E20AE23 00315463 0A30A023 // bge
0021E463 0E20AE23 00316463 0A30A223 // bltu
00317463 0E20AE23 0021F463 0A30A423 // bgeu
ABCDEC37 00001C97 00800D6F 0E20AE23 13500DE7 0E20AE23 // lui auipc jal jalr
0B80A623 0B90A823 0BA0AA23 0BB0AC23 00000073           // link stores, ecall
@080
80F27F91 12345678
@0a0
00000023
00000140 FFFFFFFE F 00000144 0000000C F 00000148 FFFFFFFC F 0000014C FFFFFFFD F
00000150 00000001 F 00000154 00000001 F 00000158 00000000 F 0000015C 000000A0 F
00000160 FFFFFFFF F 00000164 0FFFFFFF F 00000168 FFFFFFFC F 0000016C 50000000 F
00000170 00000001 F 00000174 000000F5 F
00000180 F5F5F5F5 1 00000180 F5F5F5F5 2 00000180 F5F5F5F5 4 00000180 F5F5F5F5 8
00000184 FFFCFFFC 3 00000184 FFFCFFFC C
00000178 FFFFFF80 F 0000017C 000000F2 F 00000188 FFFF80F2 F 0000018C 00007F91 F
00000190 12345678 F
00000194 00000005 F 00000198 00000005 F 0000019C 00000005 F 000001A0 00000005 F
000001A4 00000005 F 000001A8 00000005 F
000001AC ABCDE000 F 000001B0 00001120 F 000001B4 00000128 F 000001B8 00000130 F
00000001

// File: sim/tb_rv_core.sv
// testbench for the rv32i core
// instruction and data memory models with random wishbone ack delays
// store sequence, reset and halt checks from sim/rv_stim.txt
module tb_rv_core;
  import rv_pkg::*;

  localparam int mem_words = 256;
  localparam int stim_words = 512;
  localparam int data_base = 128;
  localparam int exp_base = 160;
  localparam int fetch_limit = 50;
  localparam int run_limit = 20000;
  localparam int quiet_cycles = 20;

  logic    clk;
  logic    rst;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp;
  logic    halt;

  word_t  stim [stim_words];
  word_t  imem [mem_words];
  word_t  dmem [mem_words];
  integer seed = 8240;
  int     i_cnt = -1;
  int     d_cnt = -1;
  int     n_exp;
  int     n_seen = 0;
  int     cycles;
  logic   exp_halt;

  clock_gen i_clock_gen (
    .clk(clk),
    .rst(rst)
  );

  rv_core #(
    .reset_pc(32'h0000_0000)
  ) i_rv_core (
    .clk     (clk),
    .rst     (rst),
    .ibus_req(ibus_req),
    .ibus_rsp(ibus_rsp),
    .dbus_req(dbus_req),
    .dbus_rsp(dbus_rsp),
    .halt    (halt)
  );

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_store(input string name, input wb_req_t exp, input wb_req_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected we %b adr %h dat %h sel %h actual we %b adr %h dat %h sel %h",
               name, exp.we, exp.adr, exp.dat, exp.sel, act.we, act.adr, act.dat, act.sel);
      abort_run();
    end
  endtask

  task automatic check_halt(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_idle(input string name);
    if (ibus_req.cyc || ibus_req.stb || dbus_req.cyc || dbus_req.stb) begin
      $display("a bus request was raised %s", name);
      abort_run();
    end
    check_halt(name, 1'b0, halt);
  endtask

  // k-th expected store record: address, data, sel
  function automatic wb_req_t expected_store(input int k);
    int b;
    b = exp_base + 1 + 3 * k;
    expected_store = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: stim[b],
                       sel: stim[b + 2][3:0], dat: stim[b + 1]};
  endfunction

  // both bus models answer after 0 to 3 extra cycles
  always @(posedge clk) begin
    if (rst) begin
      ibus_rsp.ack <= 1'b0;
      dbus_rsp.ack <= 1'b0;
      i_cnt <= -1;
      d_cnt <= -1;
    end else begin
      if (ibus_rsp.ack) begin
        ibus_rsp.ack <= 1'b0;
      end else if (ibus_req.stb) begin
        if (i_cnt < 0) begin
          i_cnt <= $random(seed) & 3;
        end else if (i_cnt == 0) begin
          ibus_rsp.ack <= 1'b1;
          ibus_rsp.dat <= imem[ibus_req.adr[9:2]];
          i_cnt <= -1;
        end else begin
          i_cnt <= i_cnt - 1;
        end
      end
      if (dbus_rsp.ack) begin
        dbus_rsp.ack <= 1'b0;
      end else if (dbus_req.stb) begin
        if (d_cnt < 0) begin
          d_cnt <= $random(seed) & 3;
        end else if (d_cnt == 0) begin
          dbus_rsp.ack <= 1'b1;
          dbus_rsp.dat <= dmem[dbus_req.adr[9:2]];
          d_cnt <= -1;
        end else begin
          d_cnt <= d_cnt - 1;
        end
      end
    end
  end

  // a write is checked and applied while its ack is high
  always @(negedge clk) begin
    if (!rst && dbus_rsp.ack && dbus_req.stb && dbus_req.we) begin
      if (n_seen >= n_exp) begin
        $display("store to %h appeared after all %0d expected stores", dbus_req.adr, n_exp);
        abort_run();
      end else begin
        check_store($sformatf("store %0d", n_seen), expected_store(n_seen), dbus_req);
        for (int b = 0; b < 4; b++) begin
          if (dbus_req.sel[b]) begin
            dmem[dbus_req.adr[9:2]][8*b +: 8] = dbus_req.dat[8*b +: 8];
          end
        end
        n_seen++;
      end
    end
  end

  initial begin
    ibus_rsp = '0;
    dbus_rsp = '0;
    for (int i = 0; i < stim_words; i++) begin
      stim[i] = 32'hc300_0000 ^ (word_t'(i) << 2);
    end
    $readmemh("sim/rv_stim.txt", stim);
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = (i < data_base) ? stim[i] : 32'h5a00_0000 ^ (word_t'(i) << 2);
      dmem[i] = 32'h3c00_0000 ^ (word_t'(i) << 2);
    end
    // data words sit at byte address 0x100
    for (int j = 0; j < 8; j++) begin
      dmem[64 + j] = stim[data_base + j];
    end
    n_exp = int'(stim[exp_base]);
    exp_halt = stim[exp_base + 1 + 3 * n_exp][0];

    // reset and the first cycle after it
    cycles = 0;
    do begin
      @(negedge clk);
      check_idle("around reset");
      cycles++;
      if (cycles > 10) begin
        $display("reset was not released within 10 cycles");
        abort_run();
      end
    end while (rst);

    cycles = 0;
    while (!ibus_req.stb) begin
      @(negedge clk);
      cycles++;
      if (cycles > fetch_limit) begin
        $display("no instruction fetch started after reset");
        abort_run();
      end
    end
    check_store("first fetch", '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: 32'h0,
                                 sel: 4'hf, dat: 32'h0}, ibus_req);

    cycles = 0;
    while (!halt) begin
      @(negedge clk);
      cycles++;
      if (cycles > run_limit) begin
        $display("halt did not rise within %0d cycles", run_limit);
        abort_run();
      end
    end
    // the ecall comes last, so every store goes out before halt
    if (n_seen != n_exp) begin
      $display("halt rose after only %0d of %0d expected stores", n_seen, n_exp);
      abort_run();
    end

    // a halted core stays off both buses
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (ibus_req.stb || dbus_req.stb) begin
        $display("a bus request was raised after halt");
        abort_run();
      end
      check_halt("halt held", exp_halt, halt);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: source/decode_stage.sv
// instruction decode through the format views of the union
// immediate generation, control selection, register reads
module decode_stage (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::fetch_pkt_t  pkt_in,
  output rv_pkg::reg_idx_t    rs1,
  output rv_pkg::reg_idx_t    rs2,
  input  rv_pkg::word_t       rs1_data,
  input  rv_pkg::word_t       rs2_data,
  output rv_pkg::decode_pkt_t pkt_out
);
  import rv_pkg::*;

  insn_u       insn;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;
  decode_pkt_t dec;

  // alt selects sub or sra
  function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
    alu_sel = alu_add;
    case (funct3)
      f3_add:  alu_sel = alt ? alu_sub : alu_add;
      f3_sll:  alu_sel = alu_sll;
      f3_slt:  alu_sel = alu_slt;
      f3_sltu: alu_sel = alu_sltu;
      f3_xor:  alu_sel = alu_xor;
      f3_srl:  alu_sel = alt ? alu_sra : alu_srl;
      f3_or:   alu_sel = alu_or;
      f3_and:  alu_sel = alu_and;
    endcase
  endfunction

  assign insn = pkt_in.insn;
  assign rs1 = insn.r.rs1;
  assign rs2 = insn.r.rs2;

  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign imm_s = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm, 12'h000};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  always_comb begin
    dec = '0;
    dec.valid = pkt_in.valid;
    dec.pc = pkt_in.pc;
    dec.rs1_val = rs1_data;
    dec.rs2_val = rs2_data;
    dec.rd = insn.r.rd;
    dec.funct3 = insn.r.funct3;
    dec.alu_op = alu_add;
    dec.mem_size = mem_size_e'(insn.i.funct3[1:0]);
    dec.load_unsigned = insn.i.funct3[2];
    case (insn.r.opcode)
      op_lui: begin
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op = alu_pass_b;
        dec.reg_write = 1'b1;
      end
      op_auipc: begin
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc = 1'b1;
        dec.reg_write = 1'b1;
      end
      op_jal: begin
        dec.imm = imm_j;
        dec.jump = 1'b1;
        dec.reg_write = 1'b1;
      end
      op_jalr: begin
        // alu forms rs1 + imm as the target
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.jump = insn.i.funct3 == 3'b000;
        dec.jalr = dec.jump;
        dec.reg_write = dec.jump;
      end
      op_branch: begin
        dec.imm = imm_b;
        dec.branch = insn.b.funct3[2:1] != 2'b01;
      end
      op_load: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        // no lwu and no size 3 in rv32i
        dec.load = insn.i.funct3[1:0] != 2'b11 && !(insn.i.funct3[2] && insn.i.funct3[1]);
        dec.reg_write = dec.load;
      end
      op_store: begin
        dec.imm = imm_s;
        dec.use_imm = 1'b1;
        dec.store = !insn.s.funct3[2] && insn.s.funct3[1:0] != 2'b11;
      end
      op_imm: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.alu_op = alu_sel(insn.r.funct3, insn.r.funct3 == f3_srl && insn.r.funct7[5]);
        if (insn.r.funct3 == f3_sll) begin
          dec.reg_write = insn.r.funct7 == f7_base;
        end else if (insn.r.funct3 == f3_srl) begin
          dec.reg_write = insn.r.funct7 == f7_base || insn.r.funct7 == f7_alt;
        end else begin
          dec.reg_write = 1'b1;
        end
      end
      op_reg: begin
        dec.alu_op = alu_sel(insn.r.funct3, insn.r.funct7[5]);
        dec.reg_write = insn.r.funct7 == f7_base ||
                        (insn.r.funct7 == f7_alt &&
                         (insn.r.funct3 == f3_add || insn.r.funct3 == f3_srl));
      end
      op_system: begin
        dec.halt_req = insn.i.imm == '0 && insn.i.rs1 == '0 &&
                       insn.i.funct3 == 3'b000 && insn.i.rd == '0;
      end
      default: begin
        // fence and unknown encodings retire with no effect
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_out.valid <= 1'b0;
    end else begin
      pkt_out <= dec;
    end
  end

endmodule

// File: source/execute_stage.sv
// alu, branch condition and next pc selection
// result is the link value for jumps and the byte address for memory ops
module execute_stage (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::decode_pkt_t pkt_in,
  output rv_pkg::exec_pkt_t   pkt_out
);
  import rv_pkg::*;

  word_t     op_a;
  word_t     op_b;
  word_t     alu_res;
  word_t     pc_plus4;
  word_t     target;
  logic      cond;
  logic      taken;
  exec_pkt_t res;

  assign op_a = pkt_in.use_pc ? pkt_in.pc : pkt_in.rs1_val;
  assign op_b = pkt_in.use_imm ? pkt_in.imm : pkt_in.rs2_val;

  always_comb begin
    case (pkt_in.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // branches always compare the two register values
  always_comb begin
    case (pkt_in.funct3)
      f3_beq:  cond = pkt_in.rs1_val == pkt_in.rs2_val;
      f3_bne:  cond = pkt_in.rs1_val != pkt_in.rs2_val;
      f3_blt:  cond = $signed(pkt_in.rs1_val) < $signed(pkt_in.rs2_val);
      f3_bge:  cond = $signed(pkt_in.rs1_val) >= $signed(pkt_in.rs2_val);
      f3_bltu: cond = pkt_in.rs1_val < pkt_in.rs2_val;
      f3_bgeu: cond = pkt_in.rs1_val >= pkt_in.rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign taken = pkt_in.branch && cond;
  assign pc_plus4 = pkt_in.pc + 32'd4;
  assign target = pkt_in.pc + pkt_in.imm;

  always_comb begin
    res.valid = pkt_in.valid;
    res.result = pkt_in.jump ? pc_plus4 : alu_res;
    res.store_data = pkt_in.rs2_val;
    res.mem_size = pkt_in.mem_size;
    res.load = pkt_in.load;
    res.store = pkt_in.store;
    res.load_unsigned = pkt_in.load_unsigned;
    res.rd = pkt_in.rd;
    res.reg_write = pkt_in.reg_write;
    res.halt_req = pkt_in.halt_req;
    if (pkt_in.jalr) begin
      res.next_pc = {alu_res[xlen-1:1], 1'b0};
    end else if (pkt_in.jump || taken) begin
      res.next_pc = target;
    end else begin
      res.next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_out.valid <= 1'b0;
    end else begin
      pkt_out <= res;
    end
  end

endmodule

// File: source/fetch_stage.sv
// program counter and instruction fetch over wishbone
// sticky halt once an ecall retires
module fetch_stage #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               retire,
  input  rv_pkg::word_t      next_pc,
  input  logic               halt_req,
  output rv_pkg::wb_req_t    ibus_req,
  input  rv_pkg::wb_rsp_t    ibus_rsp,
  output rv_pkg::fetch_pkt_t pkt,
  output logic               halt
);
  import rv_pkg::*;

  word_t pc;
  logic  stb;
  // first request goes out one cycle after reset
  logic  start;
  logic  done;

  assign done = stb && ibus_rsp.ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      start     <= 1'b1;
      stb       <= 1'b0;
      pc        <= reset_pc;
      halt      <= 1'b0;
      pkt.valid <= 1'b0;
    end else begin
      start     <= 1'b0;
      pkt.valid <= done;
      if (done) begin
        stb <= 1'b0;
      end else if (start) begin
        stb <= 1'b1;
      end
      if (retire) begin
        pc <= next_pc;
        if (halt_req) begin
          halt <= 1'b1;
        end else begin
          stb <= 1'b1;
        end
      end
    end
    if (done) begin
      pkt.pc   <= pc;
      pkt.insn <= ibus_rsp.dat;
    end
  end

  // read-only port, always a full word
  assign ibus_req = '{cyc: stb, stb: stb, we: 1'b0, adr: pc, sel: 4'b1111, dat: '0};

  // jump and branch targets must keep the fetch address aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    ibus_req.stb |-> (ibus_req.adr[1:0] == 2'b00));

endmodule

// File: source/memory_stage.sv
// data-bus wishbone access with byte-lane steering
// load extension, writeback and retire
module memory_stage (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::exec_pkt_t pkt_in,
  output rv_pkg::wb_req_t   dbus_req,
  input  rv_pkg::wb_rsp_t   dbus_rsp,
  output rv_pkg::wb_pkt_t   wb,
  output logic              retire,
  output rv_pkg::word_t     next_pc,
  output logic              halt_req
);
  import rv_pkg::*;

  logic       stb;
  exec_pkt_t  held;
  exec_pkt_t  cur;
  logic [1:0] offs;
  logic [3:0] sel;
  word_t      st_dat;
  word_t      lane;
  word_t      load_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      stb <= 1'b0;
    end else if (stb && dbus_rsp.ack) begin
      stb <= 1'b0;
    end else if (pkt_in.valid && (pkt_in.load || pkt_in.store)) begin
      stb <= 1'b1;
    end
    if (pkt_in.valid) begin
      held <= pkt_in;
    end
  end

  // the held copy owns the stage while a bus access is open
  assign cur = stb ? held : pkt_in;
  assign offs = held.result[1:0];

  always_comb begin
    case (held.mem_size)
      mem_byte: begin
        sel = 4'b0001 << offs;
        st_dat = {4{held.store_data[7:0]}};
      end
      mem_half: begin
        sel = offs[1] ? 4'b1100 : 4'b0011;
        st_dat = {2{held.store_data[15:0]}};
      end
      default: begin
        sel = 4'b1111;
        st_dat = held.store_data;
      end
    endcase
  end

  assign dbus_req = '{cyc: stb, stb: stb, we: held.store,
                      adr: {held.result[xlen-1:2], 2'b00}, sel: sel, dat: st_dat};

  // addressed byte or half moved down to bit 0
  assign lane = dbus_rsp.dat >> {offs, 3'b000};

  always_comb begin
    case (held.mem_size)
      mem_byte: begin
        load_val = held.load_unsigned ? {24'h000000, lane[7:0]} :
                                        {{24{lane[7]}}, lane[7:0]};
      end
      mem_half: begin
        load_val = held.load_unsigned ? {16'h0000, lane[15:0]} :
                                        {{16{lane[15]}}, lane[15:0]};
      end
      default: load_val = dbus_rsp.dat;
    endcase
  end

  assign retire = (pkt_in.valid && !(pkt_in.load || pkt_in.store)) ||
                  (stb && dbus_rsp.ack);
  assign wb = '{we: retire && cur.reg_write, rd: cur.rd,
                data: cur.load ? load_val : cur.result};
  assign next_pc = cur.next_pc;
  assign halt_req = cur.halt_req;

  // word accesses start on a word, half accesses on a half
  a_dbus_align: assert property (@(posedge clk) disable iff (rst)
    dbus_req.stb |-> ((held.mem_size != mem_word || offs == 2'b00) &&
                      !(held.mem_size == mem_half && offs[0])));

endmodule

// File: source/reg_file.sv
// 32-entry integer register file
// two combinational read ports, one synchronous write port
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::wb_pkt_t  wb
);
  import rv_pkg::*;

  localparam int num_regs = 1 << reg_addr_w;

  word_t regs [num_regs];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 stays zero even right after a writeback that targets it
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (wb.we && wb.rd == '0) |=> (regs[0] == '0));

endmodule

// File: source/rv_core.sv
// rv32i core top level
// fetch, decode, execute and memory stages with the register file
// instruction and data wishbone master ports
module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::wb_req_t ibus_req,
  input  rv_pkg::wb_rsp_t ibus_rsp,
  output rv_pkg::wb_req_t dbus_req,
  input  rv_pkg::wb_rsp_t dbus_rsp,
  output logic            halt
);
  import rv_pkg::*;

  fetch_pkt_t  f_pkt;
  decode_pkt_t d_pkt;
  exec_pkt_t   e_pkt;
  wb_pkt_t     wb;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       next_pc;
  logic        retire;
  logic        halt_req;

  fetch_stage #(
    .reset_pc(reset_pc)
  ) i_fetch (
    .clk     (clk),
    .rst     (rst),
    .retire  (retire),
    .next_pc (next_pc),
    .halt_req(halt_req),
    .ibus_req(ibus_req),
    .ibus_rsp(ibus_rsp),
    .pkt     (f_pkt),
    .halt    (halt)
  );

  decode_stage i_decode (
    .clk     (clk),
    .rst     (rst),
    .pkt_in  (f_pkt),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .pkt_out (d_pkt)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wb      (wb)
  );

  execute_stage i_execute (
    .clk    (clk),
    .rst    (rst),
    .pkt_in (d_pkt),
    .pkt_out(e_pkt)
  );

  memory_stage i_memory (
    .clk     (clk),
    .rst     (rst),
    .pkt_in  (e_pkt),
    .dbus_req(dbus_req),
    .dbus_rsp(dbus_rsp),
    .wb      (wb),
    .retire  (retire),
    .next_pc (next_pc),
    .halt_req(halt_req)
  );

endmodule

// File: source/rv_pkg.sv
// widths, opcodes and function codes of the rv32i core
// instruction word union with its six format views
// stage hand-off packets and wishbone request and response structs
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes, bits 6:0 of every instruction
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_imm      = 7'b0010011,
    op_auipc    = 7'b0010111,
    op_store    = 7'b0100011,
    op_reg      = 7'b0110011,
    op_lui      = 7'b0110111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte = 2'd0,
    mem_half = 2'd1,
    mem_word = 2'd2
  } mem_size_e;

  // funct3 of the alu operations
  localparam logic [2:0] f3_add = 3'd0;
  localparam logic [2:0] f3_sll = 3'd1;
  localparam logic [2:0] f3_slt = 3'd2;
  localparam logic [2:0] f3_sltu = 3'd3;
  localparam logic [2:0] f3_xor = 3'd4;
  localparam logic [2:0] f3_srl = 3'd5;
  localparam logic [2:0] f3_or = 3'd6;
  localparam logic [2:0] f3_and = 3'd7;

  // funct3 of the conditional branches
  localparam logic [2:0] f3_beq = 3'd0;
  localparam logic [2:0] f3_bne = 3'd1;
  localparam logic [2:0] f3_blt = 3'd4;
  localparam logic [2:0] f3_bge = 3'd5;
  localparam logic [2:0] f3_bltu = 3'd6;
  localparam logic [2:0] f3_bgeu = 3'd7;

  // funct7 for the base op and for sub / sra
  localparam logic [6:0] f7_base = 7'h00;
  localparam logic [6:0] f7_alt = 7'h20;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } insn_u;

  typedef struct packed {
    logic  valid;
    word_t pc;
    insn_u insn;
  } fetch_pkt_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    reg_idx_t   rd;
    alu_op_e    alu_op;
    logic       use_imm;
    logic       use_pc;
    logic       branch;
    logic [2:0] funct3;
    logic       jump;
    logic       jalr;
    logic       load;
    logic       store;
    logic       load_unsigned;
    mem_size_e  mem_size;
    logic       reg_write;
    logic       halt_req;
  } decode_pkt_t;

  typedef struct packed {
    logic      valid;
    word_t     result;
    word_t     store_data;
    mem_size_e mem_size;
    logic      load;
    logic      store;
    logic      load_unsigned;
    reg_idx_t  rd;
    logic      reg_write;
    word_t     next_pc;
    logic      halt_req;
  } exec_pkt_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } wb_pkt_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    logic [3:0] sel;
    word_t      dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage

// File: vlog.f
source/rv_pkg.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core.sv
sim/clock_gen.sv
sim/tb_rv_core.sv
